//--- Makefile
TOOL     = verilator
VFLAGS   = --binary --timing
TOP      = tb_kyber_pwm
FILELIST = kyber_pwm.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# the pass line in the log decides the result
test:
	$(TOOL) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- coef_counter.sv
module coef_counter (
    input  logic                           clk,
    input  logic                           reset,
    input  kyber_pwm_pkg::op_e             op,
    output logic [kyber_pwm_pkg::ADDR_W:0] count,   // one spare bit for the tail cycles
    output logic                           last
);

    logic [kyber_pwm_pkg::ADDR_W:0] limit;   // final count of current op

    always_comb begin
        case (op)
            kyber_pwm_pkg::OP_LOAD:
                limit = (kyber_pwm_pkg::ADDR_W + 1)'(kyber_pwm_pkg::LOAD_CYCLES - 1);
            kyber_pwm_pkg::OP_MULT:
                limit = (kyber_pwm_pkg::ADDR_W + 1)'(kyber_pwm_pkg::MULT_CYCLES - 1);
            kyber_pwm_pkg::OP_READ:
                limit = (kyber_pwm_pkg::ADDR_W + 1)'(kyber_pwm_pkg::READ_CYCLES - 1);
            default:
                limit = '0;   // idle has last masked below
        endcase
    end

    assign last = (op != kyber_pwm_pkg::OP_IDLE) && (count == limit);

    // op only ever changes idle->busy (count already 0)
    // or busy->idle on last, so clearing on last covers both
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            count <= '0;
        else if (op == kyber_pwm_pkg::OP_IDLE || last)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

//--- coef_ram.sv
module coef_ram (
    input  logic                   clk,
    input  kyber_pwm_pkg::mem_wr_t wr,
    input  kyber_pwm_pkg::addr_t   raddr,
    output kyber_pwm_pkg::coef_t   rdata
);

    // one polynomial in simple dual port storage
    kyber_pwm_pkg::coef_t mem [0:kyber_pwm_pkg::POLY_N-1];

    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
        rdata <= mem[raddr];   // registered read with data next cycle
    end

endmodule

//--- kyber_pwm.f
kyber_pwm_pkg.sv
pwm_fsm.sv
coef_counter.sv
coef_ram.sv
mod_mult_q.sv
poly_router.sv
kyber_pwm_top.sv
tb_kyber_pwm.sv

//--- kyber_pwm_pkg.sv
package kyber_pwm_pkg;

    // ring parameters
    localparam int KYBER_Q = 3329;         // modulus q
    localparam int POLY_N  = 256;          // coefficients per polynomial
    localparam int COEF_W  = 12;           // bits per coefficient
    localparam int ADDR_W  = 8;            // log2(POLY_N)

    // barrett reduction with m = floor(2^24 / q)
    localparam int BARRETT_M     = 5039;
    localparam int BARRETT_SHIFT = 24;

    localparam int MULT_LATENCY = 3;       // mod_mult_q stages

    // cycles spent in each busy state
    localparam int LOAD_CYCLES = POLY_N;                     // one write per cycle
    localparam int READ_CYCLES = POLY_N + 2;                 // ram read + dout reg
    localparam int MULT_CYCLES = POLY_N + 1 + MULT_LATENCY;  // ram read + pipeline

    typedef logic [COEF_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // operation state and the op field seen by counter and router
    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_LOAD = 2'd1,
        OP_MULT = 2'd2,
        OP_READ = 2'd3
    } op_e;

    typedef enum logic {
        POLY_A = 1'b0,
        POLY_B = 1'b1
    } poly_sel_e;

    // fsm -> counter / router
    typedef struct packed {
        op_e       op;
        poly_sel_e target;   // memory loaded, read or overwritten
    } ctrl_t;

    // write side of one coefficient memory
    typedef struct packed {
        logic  en;
        addr_t addr;
        coef_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;         // tag that comes back with the product
        coef_t a;
        coef_t b;
    } mult_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        coef_t prod;         // a*b mod q
    } mult_rsp_t;

endpackage

//--- kyber_pwm_top.sv
module kyber_pwm_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_a,
    input  logic                 load_b,
    input  logic                 start_mult,
    input  logic                 read_a,
    input  logic                 read_b,
    input  logic                 start_ab,
    input  kyber_pwm_pkg::coef_t din,
    output kyber_pwm_pkg::coef_t dout,
    output logic                 done
);

    kyber_pwm_pkg::ctrl_t           ctrl;
    logic [kyber_pwm_pkg::ADDR_W:0] count;
    logic                           last;
    kyber_pwm_pkg::addr_t           raddr;
    kyber_pwm_pkg::mem_wr_t         wr_a;
    kyber_pwm_pkg::mem_wr_t         wr_b;
    kyber_pwm_pkg::coef_t           rdata_a;
    kyber_pwm_pkg::coef_t           rdata_b;
    kyber_pwm_pkg::mult_req_t       req;
    kyber_pwm_pkg::mult_rsp_t       rsp;

    pwm_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .load_a     (load_a),
        .load_b     (load_b),
        .start_mult (start_mult),
        .read_a     (read_a),
        .read_b     (read_b),
        .start_ab   (start_ab),
        .last       (last),
        .ctrl       (ctrl),
        .done       (done)
    );

    coef_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .op    (ctrl.op),
        .count (count),
        .last  (last)
    );

    poly_router u_router (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .count   (count),
        .din     (din),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .raddr   (raddr),
        .wr_a    (wr_a),
        .wr_b    (wr_b),
        .req     (req),
        .rsp     (rsp),
        .dout    (dout)
    );

    // polynomial A
    coef_ram ram_a (
        .clk   (clk),
        .wr    (wr_a),
        .raddr (raddr),
        .rdata (rdata_a)
    );

    // polynomial B
    coef_ram ram_b (
        .clk   (clk),
        .wr    (wr_b),
        .raddr (raddr),
        .rdata (rdata_b)
    );

    mod_mult_q u_mult (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

endmodule

//--- mod_mult_q.sv
module mod_mult_q (
    input  logic                     clk,
    input  logic                     reset,
    input  kyber_pwm_pkg::mult_req_t req,
    output kyber_pwm_pkg::mult_rsp_t rsp
);

    // stage 1 raw product below q^2 < 2^24
    logic                               s1_valid;
    kyber_pwm_pkg::addr_t               s1_addr;
    logic [2*kyber_pwm_pkg::COEF_W-1:0] s1_prod;

    // stage 2 product plus quotient estimate
    logic                               s2_valid;
    kyber_pwm_pkg::addr_t               s2_addr;
    logic [2*kyber_pwm_pkg::COEF_W-1:0] s2_prod;
    kyber_pwm_pkg::coef_t               s2_quot;

    // stage 3 reduced result
    logic                               s3_valid;
    kyber_pwm_pkg::addr_t               s3_addr;
    kyber_pwm_pkg::coef_t               s3_prod;

    logic [3*kyber_pwm_pkg::COEF_W-1:0] barrett_full;   // p*m < 2^36
    logic [2*kyber_pwm_pkg::COEF_W-1:0] quot_q;         // quot*q
    logic [2*kyber_pwm_pkg::COEF_W-1:0] diff;
    logic [kyber_pwm_pkg::COEF_W:0]     rem;            // below 2q needs one spare bit
    logic [kyber_pwm_pkg::COEF_W:0]     q_ext;

    assign q_ext = (kyber_pwm_pkg::COEF_W + 1)'(kyber_pwm_pkg::KYBER_Q);

    assign barrett_full = (3 * kyber_pwm_pkg::COEF_W)'(s1_prod)
                        * (3 * kyber_pwm_pkg::COEF_W)'(kyber_pwm_pkg::BARRETT_M);

    assign quot_q = (2 * kyber_pwm_pkg::COEF_W)'(s2_quot)
                  * (2 * kyber_pwm_pkg::COEF_W)'(kyber_pwm_pkg::KYBER_Q);
    assign diff   = s2_prod - quot_q;
    assign rem    = diff[kyber_pwm_pkg::COEF_W:0];   // estimate low by at most one q

    // valid flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // datapath and address tag
    always_ff @(posedge clk) begin
        s1_addr <= req.addr;
        s1_prod <= req.a * req.b;   // 12x12 -> 24
        s2_addr <= s1_addr;
        s2_prod <= s1_prod;
        s2_quot <= barrett_full[kyber_pwm_pkg::BARRETT_SHIFT +: kyber_pwm_pkg::COEF_W];
        s3_addr <= s2_addr;
        s3_prod <= (rem >= q_ext) ? kyber_pwm_pkg::coef_t'(rem - q_ext)
                                  : kyber_pwm_pkg::coef_t'(rem);   // single correction
    end

    assign rsp.valid = s3_valid;
    assign rsp.addr  = s3_addr;
    assign rsp.prod  = s3_prod;

endmodule

//--- poly_router.sv
module poly_router (
    input  logic                           clk,
    input  logic                           reset,
    input  kyber_pwm_pkg::ctrl_t           ctrl,
    input  logic [kyber_pwm_pkg::ADDR_W:0] count,
    input  kyber_pwm_pkg::coef_t           din,
    input  kyber_pwm_pkg::coef_t           rdata_a,
    input  kyber_pwm_pkg::coef_t           rdata_b,
    output kyber_pwm_pkg::addr_t           raddr,     // shared by both memories
    output kyber_pwm_pkg::mem_wr_t         wr_a,
    output kyber_pwm_pkg::mem_wr_t         wr_b,
    output kyber_pwm_pkg::mult_req_t       req,
    input  kyber_pwm_pkg::mult_rsp_t       rsp,
    output kyber_pwm_pkg::coef_t           dout
);

    logic                   in_range;     // count still below POLY_N
    logic                   mult_pend_q;  // operands on rdata this cycle
    logic                   read_pend_q;  // read data on rdata this cycle
    kyber_pwm_pkg::addr_t   addr_q;       // index of data now on rdata
    kyber_pwm_pkg::mem_wr_t wr;           // write before target steering
    kyber_pwm_pkg::coef_t   rdata_sel;

    assign in_range = ~count[kyber_pwm_pkg::ADDR_W];   // POLY_N is 2^ADDR_W
    assign raddr    = count[kyber_pwm_pkg::ADDR_W-1:0];

    // din written while loading and products while multiplying
    always_comb begin
        wr = '0;
        case (ctrl.op)
            kyber_pwm_pkg::OP_LOAD: begin
                wr.en   = in_range;
                wr.addr = count[kyber_pwm_pkg::ADDR_W-1:0];
                wr.data = din;
            end
            kyber_pwm_pkg::OP_MULT: begin
                wr.en   = rsp.valid;
                wr.addr = rsp.addr;    // tag from the multiplier
                wr.data = rsp.prod;
            end
            default: ;
        endcase
    end

    always_comb begin
        wr_a    = wr;
        wr_b    = wr;
        wr_a.en = wr.en && (ctrl.target == kyber_pwm_pkg::POLY_A);
        wr_b.en = wr.en && (ctrl.target == kyber_pwm_pkg::POLY_B);
    end

    // operands come straight from the memories one cycle after the address
    assign req.valid = mult_pend_q;
    assign req.addr  = addr_q;
    assign req.a     = rdata_a;
    assign req.b     = rdata_b;

    assign rdata_sel = (ctrl.target == kyber_pwm_pkg::POLY_A) ? rdata_a : rdata_b;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mult_pend_q <= 1'b0;
            read_pend_q <= 1'b0;
            dout        <= '0;
        end else begin
            mult_pend_q <= (ctrl.op == kyber_pwm_pkg::OP_MULT) && in_range;
            read_pend_q <= (ctrl.op == kyber_pwm_pkg::OP_READ) && in_range;
            dout        <= read_pend_q ? rdata_sel : '0;   // 0 outside a read
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= count[kyber_pwm_pkg::ADDR_W-1:0];
    end

endmodule

//--- pwm_fsm.sv
module pwm_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_a,
    input  logic                 load_b,
    input  logic                 start_mult,
    input  logic                 read_a,
    input  logic                 read_b,
    input  logic                 start_ab,   // 0 -> result into A, 1 -> into B
    input  logic                 last,       // final cycle of current op
    output kyber_pwm_pkg::ctrl_t ctrl,
    output logic                 done
);

    kyber_pwm_pkg::op_e       state;
    kyber_pwm_pkg::op_e       state_nxt;
    kyber_pwm_pkg::poly_sel_e target;
    kyber_pwm_pkg::poly_sel_e target_nxt;

    // commands looked at only in idle with load before mult before read
    always_comb begin
        state_nxt  = state;
        target_nxt = target;
        case (state)
            kyber_pwm_pkg::OP_IDLE: begin
                if (load_a) begin
                    state_nxt  = kyber_pwm_pkg::OP_LOAD;
                    target_nxt = kyber_pwm_pkg::POLY_A;
                end else if (load_b) begin
                    state_nxt  = kyber_pwm_pkg::OP_LOAD;
                    target_nxt = kyber_pwm_pkg::POLY_B;
                end else if (start_mult) begin
                    state_nxt  = kyber_pwm_pkg::OP_MULT;
                    target_nxt = start_ab ? kyber_pwm_pkg::POLY_B : kyber_pwm_pkg::POLY_A;
                end else if (read_a) begin
                    state_nxt  = kyber_pwm_pkg::OP_READ;
                    target_nxt = kyber_pwm_pkg::POLY_A;
                end else if (read_b) begin
                    state_nxt  = kyber_pwm_pkg::OP_READ;
                    target_nxt = kyber_pwm_pkg::POLY_B;
                end
            end
            default: begin
                if (last)
                    state_nxt = kyber_pwm_pkg::OP_IDLE;   // busy ops all end in idle
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= kyber_pwm_pkg::OP_IDLE;
            target <= kyber_pwm_pkg::POLY_A;
            done   <= 1'b0;
        end else begin
            state  <= state_nxt;
            target <= target_nxt;   // held through idle for the router
            done   <= (state == kyber_pwm_pkg::OP_MULT) && last;   // one cycle pulse
        end
    end

    assign ctrl.op     = state;
    assign ctrl.target = target;

endmodule

//--- tb_kyber_pwm.sv
module tb_kyber_pwm;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Q_REF          = 3329;   // modulus q
    localparam int N_REF          = 256;
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int SEED           = 32'hd285ee98;
    // about 3950 cycles for 5 loads of 259, 7 reads of 262 and 3 multiplies of 263
    localparam int TIMEOUT_CYCLES = 5000;

    localparam int CMD_LOAD_A = 0;
    localparam int CMD_LOAD_B = 1;
    localparam int CMD_MULT   = 2;
    localparam int CMD_READ_A = 3;
    localparam int CMD_READ_B = 4;

    logic        clk;
    logic        reset;
    logic        load_a;
    logic        load_b;
    logic        start_mult;
    logic        read_a;
    logic        read_b;
    logic        start_ab;
    logic [11:0] din;
    logic [11:0] dout;
    logic        done;

    int model_a [N_REF];   // expected contents of the two memories
    int model_b [N_REF];
    int win_exp [N_REF];   // coefficients due on dout during a read
    bit win_on;
    int win_start;         // cycle of coefficient 0 on dout
    int done_at;           // cycle in which done must be high
    bit mon_on;
    int cyc;
    int errors;
    int test_errs;
    int tests_run;
    int tests_failed;

    kyber_pwm_top dut (
        .clk        (clk),
        .reset      (reset),
        .load_a     (load_a),
        .load_b     (load_b),
        .start_mult (start_mult),
        .read_a     (read_a),
        .read_b     (read_b),
        .start_ab   (start_ab),
        .din        (din),
        .dout       (dout),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;   // also the timeout counter

    // expected product from plain wide arithmetic
    function automatic int ref_mulmod(input int a, input int b);
        longint p;
        p = longint'(a) * longint'(b);
        return int'(p % longint'(Q_REF));
    endfunction

    // dout and done checked every cycle at the falling edge
    always @(negedge clk) begin : compare_outputs
        int  expv;
        int  idx;
        bit  exp_done;
        if (mon_on) begin
            idx  = cyc - win_start;
            expv = 0;                                      // dout idles at 0
            if (win_on && idx >= 0 && idx < N_REF)
                expv = win_exp[idx];
            if (dout !== 12'(expv)) begin
                errors++;
                $display("CHECK FAILED at %0t: dout index %0d is %0d, expected %0d",
                         $time, idx, dout, expv);
            end
            exp_done = (cyc == done_at);                   // single cycle pulse
            if (done !== exp_done) begin
                errors++;
                $display("CHECK FAILED at %0t: done is %b, expected %b",
                         $time, done, exp_done);
            end
        end
    end

    // inputs change 2 ns after the rising edge
    task automatic next_drive_point();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_drive_point();
    endtask

    // one cycle command pulse; returns just after the sampling edge e0
    task automatic issue_cmd(input int cmd, input bit ab);
        case (cmd)
            CMD_LOAD_A: load_a = 1'b1;
            CMD_LOAD_B: load_b = 1'b1;
            CMD_MULT:   start_mult = 1'b1;
            CMD_READ_A: read_a = 1'b1;
            default:    read_b = 1'b1;
        endcase
        start_ab = ab;
        next_drive_point();
        load_a     = 1'b0;
        load_b     = 1'b0;
        start_mult = 1'b0;
        read_a     = 1'b0;
        read_b     = 1'b0;
        start_ab   = 1'b0;
    endtask

    task automatic load_poly(input bit sel_b);
        issue_cmd(sel_b ? CMD_LOAD_B : CMD_LOAD_A, 1'b0);
        for (int k = 0; k < N_REF; k++) begin
            din = sel_b ? 12'(model_b[k]) : 12'(model_a[k]);   // sampled at e0+1+k
            next_drive_point();
        end
        din = '0;
        idle_cycles(2);
    endtask

    // read back against the model with a latency of 2 from e0
    task automatic read_poly(input bit sel_b);
        for (int k = 0; k < N_REF; k++)
            win_exp[k] = sel_b ? model_b[k] : model_a[k];
        issue_cmd(sel_b ? CMD_READ_B : CMD_READ_A, 1'b0);
        win_start = cyc + 2;
        win_on    = 1'b1;
        while (cyc < win_start + N_REF + 2)
            next_drive_point();
        win_on = 1'b0;
        idle_cycles(1);
    endtask

    // multiply with an optional read_b poke while busy
    task automatic mult_poly(input bit into_b, input bit poke_read);
        int e0;
        issue_cmd(CMD_MULT, into_b);
        e0      = cyc;
        done_at = e0 + N_REF + 4;   // N + 1 + pipeline depth 3
        while (done !== 1'b1) begin
            read_b = poke_read && (cyc == e0 + 40);   // ignored outside idle
            next_drive_point();
        end
        read_b = 1'b0;
        for (int i = 0; i < N_REF; i++) begin
            if (into_b)
                model_b[i] = ref_mulmod(model_a[i], model_b[i]);
            else
                model_a[i] = ref_mulmod(model_a[i], model_b[i]);
        end
        idle_cycles(2);
        done_at = -1;
    endtask

    task automatic fill_random(input bit sel_b);
        for (int i = 0; i < N_REF; i++) begin
            if (sel_b)
                model_b[i] = int'($urandom % Q_REF);
            else
                model_a[i] = int'($urandom % Q_REF);
        end
    endtask

    task automatic start_test();
        test_errs = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errs) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errs);
        end
    endtask

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("run timed out after %0d cycles, DUT did not finish", cyc);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int edge_v [3];
        void'($urandom(SEED));
        reset      = 1'b1;
        load_a     = 1'b0;
        load_b     = 1'b0;
        start_mult = 1'b0;
        read_a     = 1'b0;
        read_b     = 1'b0;
        start_ab   = 1'b0;
        din        = '0;
        win_on     = 1'b0;
        win_start  = 0;
        done_at    = -1;
        mon_on     = 1'b0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        edge_v[0]  = 0;
        edge_v[1]  = 1;
        edge_v[2]  = Q_REF - 1;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset  = 1'b0;
        mon_on = 1'b1;

        // quiet outputs after reset
        start_test();
        if (dout !== 12'd0 || done !== 1'b0) begin
            errors++;
            $display("CHECK FAILED at %0t: dout %0d done %b after reset", $time, dout, done);
        end
        idle_cycles(20);
        end_test("reset_idle");

        start_test();
        fill_random(1'b0);
        fill_random(1'b1);
        load_poly(1'b0);
        load_poly(1'b1);
        read_poly(1'b0);
        read_poly(1'b1);
        end_test("load_read");

        start_test();
        mult_poly(1'b0, 1'b0);   // product lands in A
        read_poly(1'b0);
        read_poly(1'b1);         // B untouched
        end_test("mult_into_a");

        start_test();
        fill_random(1'b0);
        load_poly(1'b0);
        mult_poly(1'b1, 1'b0);   // new A times old B into B
        read_poly(1'b1);
        read_poly(1'b0);
        end_test("mult_into_b");

        // all pairs of 0, 1, q-1
        start_test();
        for (int i = 0; i < N_REF; i++) begin
            model_a[i] = edge_v[i % 3];
            model_b[i] = edge_v[(i / 3) % 3];
        end
        load_poly(1'b0);
        load_poly(1'b1);
        mult_poly(1'b0, 1'b1);   // stray read_b mid multiply
        read_poly(1'b0);
        end_test("edge_values");

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
